/* source/pktBufPkg.sv */
package pktBufPkg;

    // Width of one payload byte on every data path
    localparam int DATA_WID = 8;

    // The buffer has exactly two receive channels
    localparam int NUM_CH = 2;

    // Bits needed to name a channel, which is also the RAM address prefix
    localparam int CH_WID = $clog2(NUM_CH);

    // Channel index, used for port selection and as the RAM address high bits
    typedef enum logic [CH_WID-1:0] {
        CH0 = 1'b0,
        CH1 = 1'b1
    } chanE;

    // Receive state of the packet checker
    // IDLE waits for a start beat, BODY writes payload, DROP swallows an oversize packet
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BODY = 2'd1,
        DROP = 2'd2
    } chkStateE;

endpackage

/* source/memPortIf.sv */
`timescale 1ns/1ps

// One FIFO's view of the shared RAM
// The FIFO holds req as a level while it has a byte to offer and room for it,
// and the arbiter answers with gnt in the same cycle
interface memPortIf #(
    parameter int ADDR_WID = 4
);

    logic                           req;
    logic                           gnt;
    logic [ADDR_WID-1:0]            waddr;
    logic [pktBufPkg::DATA_WID-1:0] wdata;
    logic [ADDR_WID-1:0]            raddr;
    logic [pktBufPkg::DATA_WID-1:0] rdata;

    // FIFO side
    modport client (
        output req, waddr, wdata, raddr,
        input  gnt, rdata
    );

    // Arbiter side
    modport arbiter (
        input  req, waddr, wdata, raddr,
        output gnt, rdata
    );

endinterface

/* source/sharedRam.sv */
`timescale 1ns/1ps

module sharedRam #(
    parameter int ADDR_WID = 4
) (
    input  logic                                     CLK,
    input  logic                                     wen,
    input  logic [ADDR_WID+pktBufPkg::CH_WID-1:0]    waddr,
    input  logic [pktBufPkg::DATA_WID-1:0]           wdata,
    input  logic [ADDR_WID+pktBufPkg::CH_WID-1:0]    raddr0,
    input  logic [ADDR_WID+pktBufPkg::CH_WID-1:0]    raddr1,
    output logic [pktBufPkg::DATA_WID-1:0]           rdata0,
    output logic [pktBufPkg::DATA_WID-1:0]           rdata1
);

    // Full address is the channel index above the per-channel offset
    localparam int RAM_AWID = ADDR_WID + pktBufPkg::CH_WID;
    localparam int DEPTH    = 2 ** RAM_AWID;

    // Storage for both channels, each channel owns one half of the array
    logic [pktBufPkg::DATA_WID-1:0] mem [DEPTH];

    // Single write port, shared through the arbiter
    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // Both reads are asynchronous so each FIFO output follows its read pointer
    // in the same cycle the pointer moves
    assign rdata0 = mem[raddr0];
    assign rdata1 = mem[raddr1];

endmodule

/* source/memArbiter.sv */
`timescale 1ns/1ps

module memArbiter #(
    parameter int ADDR_WID = 4
) (
    input  logic                                     CLK,
    input  logic                                     rstN,
    memPortIf.arbiter                                port0,
    memPortIf.arbiter                                port1,
    output logic                                     ramWen,
    output logic [ADDR_WID+pktBufPkg::CH_WID-1:0]    ramWaddr,
    output logic [pktBufPkg::DATA_WID-1:0]           ramWdata,
    output logic [ADDR_WID+pktBufPkg::CH_WID-1:0]    ramRaddr0,
    output logic [ADDR_WID+pktBufPkg::CH_WID-1:0]    ramRaddr1,
    input  logic [pktBufPkg::DATA_WID-1:0]           ramRdata0,
    input  logic [pktBufPkg::DATA_WID-1:0]           ramRdata1
);

    // Channel that won the write port most recently
    pktBufPkg::chanE lastWin;
    // Channel that owns the write port in this cycle
    pktBufPkg::chanE winner;
    logic gnt0;
    logic gnt1;

    // Round robin between the two requesters
    // A lone requester is granted at once
    // Under contention the channel that did not win last time goes first,
    // so nobody waits more than one cycle
    always_comb begin
        gnt0 = 1'b0;
        gnt1 = 1'b0;
        if (port0.req && port1.req) begin
            if (lastWin == pktBufPkg::CH0) begin
                gnt1 = 1'b1;
            end else begin
                gnt0 = 1'b1;
            end
        end else begin
            gnt0 = port0.req;
            gnt1 = port1.req;
        end
    end

    assign port0.gnt = gnt0;
    assign port1.gnt = gnt1;

    // History only moves when somebody actually wrote
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            lastWin <= pktBufPkg::CH0;
        end else if (gnt0) begin
            lastWin <= pktBufPkg::CH0;
        end else if (gnt1) begin
            lastWin <= pktBufPkg::CH1;
        end
    end

    // The write port carries the winner, whose channel becomes the address high bits
    assign winner   = gnt1 ? pktBufPkg::CH1 : pktBufPkg::CH0;
    assign ramWen   = gnt0 || gnt1;
    assign ramWaddr = {winner, (winner == pktBufPkg::CH1) ? port1.waddr : port0.waddr};
    assign ramWdata = (winner == pktBufPkg::CH1) ? port1.wdata : port0.wdata;

    // Each read port is dedicated to one channel
    assign ramRaddr0   = {pktBufPkg::CH0, port0.raddr};
    assign ramRaddr1   = {pktBufPkg::CH1, port1.raddr};
    assign port0.rdata = ramRdata0;
    assign port1.rdata = ramRdata1;

    // The write port is never handed to both FIFOs at once
    assert property (@(posedge CLK) disable iff (!rstN) !(port0.gnt && port1.gnt));

    // A FIFO only ever sees a grant while it is asking for one
    assert property (@(posedge CLK) disable iff (!rstN) port0.gnt |-> port0.req);
    assert property (@(posedge CLK) disable iff (!rstN) port1.gnt |-> port1.req);

endmodule

/* source/transFifo.sv */
`timescale 1ns/1ps

module transFifo #(
    parameter int ADDR_WID = 4,
    parameter int ENTRIES  = 12
) (
    input  logic                           CLK,
    input  logic                           rstN,
    memPortIf.client                       mem,
    input  logic                           wrValid,
    input  logic [pktBufPkg::DATA_WID-1:0] wrData,
    output logic                           wrAccept,
    output logic                           full,
    input  logic                           fillTransDone,
    input  logic                           fillTransSuccess,
    input  logic                           popData,
    input  logic                           popTransDone,
    input  logic                           popTransSuccess,
    output logic                           dataAvailable,
    output logic [pktBufPkg::DATA_WID-1:0] dataOut
);

    // Committed pointers only move when a transaction ends with success,
    // the tentative ones follow every handshake and fall back on failure
    logic [ADDR_WID-1:0] wrCommit;
    logic [ADDR_WID-1:0] wrTrans;
    logic [ADDR_WID-1:0] rdCommit;
    logic [ADDR_WID-1:0] rdTrans;
    logic [ADDR_WID-1:0] wrTransNext;
    logic [ADDR_WID-1:0] rdTransNext;
    logic                readHandshake;

    generate
        if (ENTRIES == 2 ** ADDR_WID) begin : gFullSpace
            // Every address is backed, so the counters simply overflow
            assign wrTransNext = wrTrans + 1'b1;
            assign rdTransNext = rdTrans + 1'b1;
        end else begin : gBounded
            // Only part of the address space is backed, wrap explicitly at ENTRIES
            assign wrTransNext = (wrTrans == ADDR_WID'(ENTRIES - 1)) ? '0 : wrTrans + 1'b1;
            assign rdTransNext = (rdTrans == ADDR_WID'(ENTRIES - 1)) ? '0 : rdTrans + 1'b1;
        end
    endgenerate

    // One slot always stays empty to tell full from empty
    // Only committed reads free space, a pending pop may still be rewound
    assign full = wrTransNext == rdCommit;

    // Readers only see data whose fill transaction has been committed
    assign dataAvailable = rdTrans != wrCommit;
    assign readHandshake = dataAvailable && popData;

    // Ask for the write port while a byte is offered and there is room
    assign mem.req   = wrValid && !full;
    assign mem.waddr = wrTrans;
    assign mem.wdata = wrData;
    assign wrAccept  = mem.gnt;

    // Read side follows the tentative pointer combinationally
    assign mem.raddr = rdTrans;
    assign dataOut   = mem.rdata;

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            wrCommit <= '0;
            wrTrans  <= '0;
        end else if (fillTransDone) begin
            if (fillTransSuccess) begin
                // Make the whole packet visible to the reader
                wrCommit <= wrTrans;
            end else begin
                // Throw away everything written since the last commit
                wrTrans <= wrCommit;
            end
        end else if (mem.gnt) begin
            // The grant already implies our request, no need to check again
            wrTrans <= wrTransNext;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            rdCommit <= '0;
            rdTrans  <= '0;
        end else if (popTransDone) begin
            if (popTransSuccess) begin
                // Consumed bytes are released for new writes
                rdCommit <= rdTrans;
            end else begin
                // Rewind so the same bytes are read again
                rdTrans <= rdCommit;
            end
        end else if (readHandshake) begin
            rdTrans <= rdTransNext;
        end
    end

    // The writer never ends its transaction in a cycle where a byte is granted
    assert property (@(posedge CLK) disable iff (!rstN)
        fillTransDone |-> !(wrValid && wrAccept));

    // The consumer never ends its transaction while a pop is taking effect
    assert property (@(posedge CLK) disable iff (!rstN)
        popTransDone |-> !(popData && dataAvailable));

endmodule

/* source/packetChecker.sv */
`timescale 1ns/1ps

module packetChecker #(
    parameter int MAX_PKT = 8
) (
    input  logic                           CLK,
    input  logic                           rstN,
    input  logic                           inValid,
    input  logic                           inSop,
    input  logic                           inEop,
    input  logic [pktBufPkg::DATA_WID-1:0] inData,
    output logic                           inReady,
    output logic                           wrValid,
    output logic [pktBufPkg::DATA_WID-1:0] wrData,
    input  logic                           wrAccept,
    output logic                           fillTransDone,
    output logic                           fillTransSuccess
);

    localparam int CNT_WID = $clog2(MAX_PKT + 1);

    pktBufPkg::chkStateE            state;
    pktBufPkg::chkStateE            stateNext;
    logic [CNT_WID-1:0]             count;
    logic [pktBufPkg::DATA_WID-1:0] csum;
    logic                           isPayload;
    logic                           isEnd;

    // A start beat carries the first payload byte, the end beat carries the checksum
    assign isEnd     = inValid && inEop;
    assign isPayload = inValid && !inEop &&
        ((state == pktBufPkg::IDLE && inSop) ||
         (state == pktBufPkg::BODY && count != CNT_WID'(MAX_PKT)));

    // Payload goes straight to the FIFO, the checksum byte never does
    assign wrValid = isPayload;
    assign wrData  = inData;

    always_comb begin
        stateNext        = state;
        fillTransDone    = 1'b0;
        fillTransSuccess = 1'b0;
        inReady          = 1'b0;
        if (isPayload) begin
            // Payload waits for the write port, then enters the packet
            inReady = wrAccept;
            if (wrAccept) begin
                stateNext = pktBufPkg::BODY;
            end
        end else if (isEnd) begin
            // End beat is always taken and closes the fill transaction
            inReady          = 1'b1;
            fillTransDone    = 1'b1;
            fillTransSuccess = (state == pktBufPkg::BODY) && (count != '0) && (csum == inData);
            stateNext        = pktBufPkg::IDLE;
        end else if (inValid) begin
            // Stray beats in IDLE and bytes past MAX_PKT are swallowed
            inReady = 1'b1;
            if (state == pktBufPkg::BODY) begin
                stateNext = pktBufPkg::DROP;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            state <= pktBufPkg::IDLE;
            count <= '0;
        end else begin
            state <= stateNext;
            if (isEnd) begin
                count <= '0;
            end else if (isPayload && wrAccept) begin
                count <= count + 1'b1;
            end
        end
    end

    // Running XOR restarts with the first byte of each packet
    always_ff @(posedge CLK) begin
        if (isPayload && wrAccept) begin
            csum <= (state == pktBufPkg::IDLE) ? inData : (csum ^ inData);
        end
    end

    // Mid-packet the source never marks one beat as both start and end
    assert property (@(posedge CLK) disable iff (!rstN)
        (inValid && state != pktBufPkg::IDLE) |-> !(inSop && inEop));

endmodule

/* source/pktBufTop.sv */
`timescale 1ns/1ps

module pktBufTop #(
    parameter int ADDR_WID = 4,
    parameter int ENTRIES  = 12,
    parameter int MAX_PKT  = 8
) (
    input  logic                                                  CLK,
    input  logic                                                  rstN,
    input  logic [pktBufPkg::NUM_CH-1:0]                          inValid,
    input  logic [pktBufPkg::NUM_CH-1:0]                          inSop,
    input  logic [pktBufPkg::NUM_CH-1:0]                          inEop,
    input  logic [pktBufPkg::NUM_CH-1:0][pktBufPkg::DATA_WID-1:0] inData,
    output logic [pktBufPkg::NUM_CH-1:0]                          inReady,
    input  logic [pktBufPkg::NUM_CH-1:0]                          popData,
    input  logic [pktBufPkg::NUM_CH-1:0]                          popTransDone,
    input  logic [pktBufPkg::NUM_CH-1:0]                          popTransSuccess,
    output logic [pktBufPkg::NUM_CH-1:0]                          dataAvailable,
    output logic [pktBufPkg::NUM_CH-1:0][pktBufPkg::DATA_WID-1:0] dataOut
);

    localparam int RAM_AWID = ADDR_WID + pktBufPkg::CH_WID;

    // Checker to FIFO, one lane per channel
    logic [pktBufPkg::NUM_CH-1:0]                          wrValid;
    logic [pktBufPkg::NUM_CH-1:0][pktBufPkg::DATA_WID-1:0] wrData;
    logic [pktBufPkg::NUM_CH-1:0]                          wrAccept;
    logic [pktBufPkg::NUM_CH-1:0]                          fillTransDone;
    logic [pktBufPkg::NUM_CH-1:0]                          fillTransSuccess;

    // Arbiter to RAM
    logic                           ramWen;
    logic [RAM_AWID-1:0]            ramWaddr;
    logic [pktBufPkg::DATA_WID-1:0] ramWdata;
    logic [RAM_AWID-1:0]            ramRaddr0;
    logic [RAM_AWID-1:0]            ramRaddr1;
    logic [pktBufPkg::DATA_WID-1:0] ramRdata0;
    logic [pktBufPkg::DATA_WID-1:0] ramRdata1;

    // A packet that passes the length check must always fit in an empty FIFO
    if (MAX_PKT > ENTRIES - 1) begin : gBadMaxPkt
        $error("MAX_PKT must not exceed ENTRIES-1");
    end
    if (ENTRIES > 2 ** ADDR_WID) begin : gBadEntries
        $error("ENTRIES does not fit in ADDR_WID address bits");
    end

    memPortIf #(.ADDR_WID(ADDR_WID)) port0 ();
    memPortIf #(.ADDR_WID(ADDR_WID)) port1 ();

    packetChecker #(.MAX_PKT(MAX_PKT)) i_chk0 (
        .CLK(CLK), .rstN(rstN),
        .inValid(inValid[pktBufPkg::CH0]), .inSop(inSop[pktBufPkg::CH0]),
        .inEop(inEop[pktBufPkg::CH0]), .inData(inData[pktBufPkg::CH0]),
        .inReady(inReady[pktBufPkg::CH0]),
        .wrValid(wrValid[pktBufPkg::CH0]), .wrData(wrData[pktBufPkg::CH0]),
        .wrAccept(wrAccept[pktBufPkg::CH0]),
        .fillTransDone(fillTransDone[pktBufPkg::CH0]),
        .fillTransSuccess(fillTransSuccess[pktBufPkg::CH0])
    );

    packetChecker #(.MAX_PKT(MAX_PKT)) i_chk1 (
        .CLK(CLK), .rstN(rstN),
        .inValid(inValid[pktBufPkg::CH1]), .inSop(inSop[pktBufPkg::CH1]),
        .inEop(inEop[pktBufPkg::CH1]), .inData(inData[pktBufPkg::CH1]),
        .inReady(inReady[pktBufPkg::CH1]),
        .wrValid(wrValid[pktBufPkg::CH1]), .wrData(wrData[pktBufPkg::CH1]),
        .wrAccept(wrAccept[pktBufPkg::CH1]),
        .fillTransDone(fillTransDone[pktBufPkg::CH1]),
        .fillTransSuccess(fillTransSuccess[pktBufPkg::CH1])
    );

    // Full is only used inside the FIFO to hold back its write request
    transFifo #(.ADDR_WID(ADDR_WID), .ENTRIES(ENTRIES)) i_fifo0 (
        .CLK(CLK), .rstN(rstN), .mem(port0),
        .wrValid(wrValid[pktBufPkg::CH0]), .wrData(wrData[pktBufPkg::CH0]),
        .wrAccept(wrAccept[pktBufPkg::CH0]), .full(),
        .fillTransDone(fillTransDone[pktBufPkg::CH0]),
        .fillTransSuccess(fillTransSuccess[pktBufPkg::CH0]),
        .popData(popData[pktBufPkg::CH0]), .popTransDone(popTransDone[pktBufPkg::CH0]),
        .popTransSuccess(popTransSuccess[pktBufPkg::CH0]),
        .dataAvailable(dataAvailable[pktBufPkg::CH0]), .dataOut(dataOut[pktBufPkg::CH0])
    );

    transFifo #(.ADDR_WID(ADDR_WID), .ENTRIES(ENTRIES)) i_fifo1 (
        .CLK(CLK), .rstN(rstN), .mem(port1),
        .wrValid(wrValid[pktBufPkg::CH1]), .wrData(wrData[pktBufPkg::CH1]),
        .wrAccept(wrAccept[pktBufPkg::CH1]), .full(),
        .fillTransDone(fillTransDone[pktBufPkg::CH1]),
        .fillTransSuccess(fillTransSuccess[pktBufPkg::CH1]),
        .popData(popData[pktBufPkg::CH1]), .popTransDone(popTransDone[pktBufPkg::CH1]),
        .popTransSuccess(popTransSuccess[pktBufPkg::CH1]),
        .dataAvailable(dataAvailable[pktBufPkg::CH1]), .dataOut(dataOut[pktBufPkg::CH1])
    );

    memArbiter #(.ADDR_WID(ADDR_WID)) i_arb (
        .CLK(CLK), .rstN(rstN), .port0(port0), .port1(port1),
        .ramWen(ramWen), .ramWaddr(ramWaddr), .ramWdata(ramWdata),
        .ramRaddr0(ramRaddr0), .ramRaddr1(ramRaddr1),
        .ramRdata0(ramRdata0), .ramRdata1(ramRdata1)
    );

    sharedRam #(.ADDR_WID(ADDR_WID)) i_ram (
        .CLK(CLK), .wen(ramWen), .waddr(ramWaddr), .wdata(ramWdata),
        .raddr0(ramRaddr0), .raddr1(ramRaddr1),
        .rdata0(ramRdata0), .rdata1(ramRdata1)
    );

endmodule

/* verif/pktBufTb.sv */
`timescale 1ns/1ps

module pktBufTb;

    localparam int ADDR_WID = 4;
    localparam int ENTRIES  = 12;
    localparam int MAX_PKT  = 8;
    localparam int NUM_CH   = pktBufPkg::NUM_CH;
    localparam int NUM_PKTS = 40;
    localparam logic [31:0] SEED = 32'h4ccf;
    // Cycle limits of the individual wait loops
    localparam int READY_TIMEOUT = 200;
    localparam int AVAIL_TIMEOUT = 8;
    localparam int IDLE_TIMEOUT  = 2000;

    typedef logic [pktBufPkg::DATA_WID-1:0] byteT;

    logic CLK = 1'b0;
    logic rstN;
    logic [NUM_CH-1:0]                          inValid, inSop, inEop, inReady;
    logic [NUM_CH-1:0][pktBufPkg::DATA_WID-1:0] inData, dataOut;
    logic [NUM_CH-1:0]                          popData, popTransDone, popTransSuccess;
    logic [NUM_CH-1:0]                          dataAvailable;

    // Expected payload per channel, filled at each good end beat
    byteT              refQ [NUM_CH][$];
    logic [NUM_CH-1:0] prodDone;
    int                errors;
    int                monErrors = 0;

    // Occupancy model of each FIFO, kept by the monitor only
    int   committed [NUM_CH];
    int   popped [NUM_CH];
    int   beats [NUM_CH];
    int   waits [NUM_CH];
    byteT runSum [NUM_CH];

    pktBufTop #(.ADDR_WID(ADDR_WID), .ENTRIES(ENTRIES), .MAX_PKT(MAX_PKT)) i_dut (
        .CLK(CLK), .rstN(rstN),
        .inValid(inValid), .inSop(inSop), .inEop(inEop), .inData(inData), .inReady(inReady),
        .popData(popData), .popTransDone(popTransDone), .popTransSuccess(popTransSuccess),
        .dataAvailable(dataAvailable), .dataOut(dataOut)
    );

    always #10 CLK = ~CLK;

    function automatic logic [31:0] lcgStep(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Looks at every channel once per cycle, after the falling edge drive has settled
    // Everything seen here takes effect at the next rising edge
    always @(negedge CLK) begin
        #2;
        for (int ch = 0; ch < NUM_CH; ch++) begin : chanCheck
            int occ;
            // Bytes written so far in the open packet, a dropped tail is never written
            occ = committed[ch] + ((beats[ch] < MAX_PKT) ? beats[ch] : MAX_PKT);
            if (!rstN) begin
                committed[ch] = 0;
                popped[ch]    = 0;
                beats[ch]     = 0;
                waits[ch]     = 0;
                runSum[ch]    = '0;
            end else begin
                // Readable means committed bytes that the reader has not passed yet
                assert (dataAvailable[ch] === (committed[ch] > popped[ch])) else begin
                    monErrors++;
                    $display("ERROR: dataAvailable[%0d] expected %h actual %h", ch,
                        committed[ch] > popped[ch], dataAvailable[ch]);
                end
                if (inValid[ch] && !inEop[ch]) begin
                    if (beats[ch] >= MAX_PKT || occ < ENTRIES - 1) begin
                        // Bytes of a dropped packet go at once, payload loses one round at most
                        if (inReady[ch] !== 1'b1) begin
                            waits[ch]++;
                        end
                        assert (beats[ch] < MAX_PKT || inReady[ch] === 1'b1) else begin
                            monErrors++;
                            $display("ERROR: inReady[%0d] expected 1 actual %h", ch, inReady[ch]);
                        end
                        assert (waits[ch] <= 1) else begin
                            monErrors++;
                            $display("Channel %0d waited more than one cycle with room free", ch);
                        end
                    end else begin
                        // The FIFO is full, the byte has to be held back
                        assert (inReady[ch] === 1'b0) else begin
                            monErrors++;
                            $display("ERROR: inReady[%0d] expected 0 actual %h", ch, inReady[ch]);
                        end
                    end
                    if (inReady[ch] === 1'b1) begin
                        beats[ch]++;
                        runSum[ch] = runSum[ch] ^ inData[ch];
                        waits[ch]  = 0;
                    end
                end else if (inValid[ch] && inEop[ch]) begin
                    assert (inReady[ch] === 1'b1) else begin
                        monErrors++;
                        $display("ERROR: inReady[%0d] expected 1 actual %h", ch, inReady[ch]);
                    end
                    if (beats[ch] > 0 && beats[ch] <= MAX_PKT && runSum[ch] == inData[ch]) begin
                        committed[ch] += beats[ch];
                    end
                    beats[ch]  = 0;
                    runSum[ch] = '0;
                end
                // A successful pop frees what was read, a failed one rewinds the reader
                if (popTransDone[ch]) begin
                    if (popTransSuccess[ch]) begin
                        committed[ch] -= popped[ch];
                    end
                    popped[ch] = 0;
                end else if (popData[ch] && dataAvailable[ch]) begin
                    popped[ch]++;
                end
            end
        end
    end

    // Puts one beat on a channel and holds it until inReady
    task automatic sendBeat(input int ch, input logic sop, input logic eop, input byteT data);
        int waited;
        @(negedge CLK);
        inValid[ch] = 1'b1;
        inSop[ch]   = sop;
        inEop[ch]   = eop;
        inData[ch]  = data;
        #1;
        waited = 0;
        while (inReady[ch] !== 1'b1 && waited < READY_TIMEOUT) begin
            @(negedge CLK);
            #1;
            waited++;
        end
        assert (inReady[ch] === 1'b1) else begin
            errors++;
            $display("Channel %0d beat was not accepted within %0d cycles", ch, READY_TIMEOUT);
        end
    endtask

    // Random packets, some with a bad checksum and some longer than MAX_PKT
    task automatic runProducer(input int ch);
        logic [31:0] rnd;
        int          len;
        int          gap;
        logic        corrupt;
        byteT        payload [$];
        byteT        sum;
        rnd = lcgStep(SEED + 32'(ch));
        for (int p = 0; p < NUM_PKTS; p++) begin
            rnd     = lcgStep(rnd);
            len     = 1 + int'((rnd >> 16) % (MAX_PKT + 2));
            rnd     = lcgStep(rnd);
            corrupt = rnd[18:16] == 3'd0;
            gap     = (rnd[21:20] == 2'd0) ? int'(rnd[24:22]) : 0;
            payload.delete();
            sum = '0;
            for (int i = 0; i < len; i++) begin
                rnd = lcgStep(rnd);
                payload.push_back(rnd[23:16]);
                sum = sum ^ rnd[23:16];
            end
            for (int i = 0; i < len; i++) begin
                sendBeat(ch, i == 0, 1'b0, payload[i]);
            end
            // Forcing the low bit makes sure the bad checksum really differs
            rnd = lcgStep(rnd);
            sendBeat(ch, 1'b0, 1'b1, corrupt ? (sum ^ (rnd[23:16] | 8'h01)) : sum);
            if (!corrupt && len <= MAX_PKT) begin
                foreach (payload[i]) begin
                    refQ[ch].push_back(payload[i]);
                end
            end
            if (gap > 0) begin
                @(negedge CLK);
                inValid[ch] = 1'b0;
                repeat (gap - 1) @(negedge CLK);
            end
        end
        @(negedge CLK);
        inValid[ch]  = 1'b0;
        prodDone[ch] = 1'b1;
    endtask

    // Reads random spans of committed data and ends each span with or without success
    task automatic runConsumer(input int ch);
        logic [31:0] rnd;
        int          target;
        int          idx;
        int          waited;
        int          idle;
        logic        keep;
        logic        stalled;
        rnd     = lcgStep(SEED + 32'(ch) + 32'd2);
        idle    = 0;
        stalled = 1'b0;
        while (!(prodDone[ch] && refQ[ch].size() == 0) && idle < IDLE_TIMEOUT && !stalled) begin
            rnd = lcgStep(rnd);
            if (refQ[ch].size() == 0 || rnd[17:16] == 2'd0) begin
                // Pauses let the writer run into a full FIFO now and then
                @(negedge CLK);
                popData[ch]      = 1'b0;
                popTransDone[ch] = 1'b0;
                idle = (refQ[ch].size() == 0) ? idle + 1 : 0;
            end else begin
                idle   = 0;
                target = 1 + int'((rnd >> 18) % refQ[ch].size());
                keep   = rnd[31:30] != 2'd0;
                idx    = 0;
                while (idx < target && !stalled) begin
                    @(negedge CLK);
                    popData[ch]      = 1'b1;
                    popTransDone[ch] = 1'b0;
                    #1;
                    waited = 0;
                    while (dataAvailable[ch] !== 1'b1 && waited < AVAIL_TIMEOUT) begin
                        @(negedge CLK);
                        #1;
                        waited++;
                    end
                    stalled = dataAvailable[ch] !== 1'b1;
                    assert (!stalled) else begin
                        errors++;
                        $display("Channel %0d had committed bytes but no data available", ch);
                    end
                    if (!stalled) begin
                        assert (dataOut[ch] === refQ[ch][idx]) else begin
                            errors++;
                            $display("ERROR: dataOut[%0d] expected %h actual %h", ch,
                                refQ[ch][idx], dataOut[ch]);
                        end
                        idx++;
                    end
                end
                // A failed transaction must replay the same bytes from the start
                @(negedge CLK);
                popData[ch]         = 1'b0;
                popTransDone[ch]    = 1'b1;
                popTransSuccess[ch] = keep;
                if (keep) begin
                    repeat (idx) refQ[ch].delete(0);
                end
            end
        end
        @(negedge CLK);
        popData[ch]      = 1'b0;
        popTransDone[ch] = 1'b0;
        assert (idle < IDLE_TIMEOUT) else begin
            errors++;
            $display("Channel %0d consumer waited too long for the producer", ch);
        end
    endtask

    initial begin
        rstN            = 1'b0;
        inValid         = '0;
        inSop           = '0;
        inEop           = '0;
        inData          = '0;
        popData         = '0;
        popTransDone    = '0;
        popTransSuccess = '0;
        prodDone        = '0;
        errors          = 0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        rstN = 1'b1;
        #1;
        // Nothing is readable and nothing is accepted before any input
        assert (dataAvailable === '0) else begin
            errors++;
            $display("ERROR: dataAvailable expected 0 actual %h", dataAvailable);
        end
        assert (inReady === '0) else begin
            errors++;
            $display("ERROR: inReady expected 0 actual %h", inReady);
        end
        fork
            runProducer(0);
            runProducer(1);
            runConsumer(0);
            runConsumer(1);
        join
        // A few more cycles so the monitor sees both FIFOs drained
        repeat (4) @(negedge CLK);
        $display("Checks done with %0d stream errors and %0d monitor errors", errors, monErrors);
        if (errors == 0 && monErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* all.f */
source/pktBufPkg.sv
source/memPortIf.sv
source/sharedRam.sv
source/memArbiter.sv
source/transFifo.sv
source/packetChecker.sv
source/pktBufTop.sv
verif/pktBufTb.sv

/* run.sh */
#!/bin/sh
# Build and run the packet buffer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module pktBufTb -f all.f -o pktBufSim
./obj_dir/pktBufSim | tee sim.log
# The run counts as passed only if the pass line is in the log
grep -q "^Test passed$" sim.log
